// File: src/main_buf_pkg.sv
package main_buf_pkg;

   // --------------------------------------------------
   // Data types
   // --------------------------------------------------

   // One stream word as it arrives on data_in
   typedef logic        [31:0] word_t;

   // Window cells and bias
   typedef logic        [7:0]  pixel_t;
   typedef logic signed [7:0]  weight_t;
   typedef logic signed [31:0] bias_t;

   // Command byte, top of an image word
   typedef logic        [7:0]  cmd_t;

   // Word position inside a phase
   typedef logic        [1:0]  idx_t;

   // Frame phases, in stream order
   typedef enum logic [1:0] {
      PH_IFM  = 2'd0,
      PH_WGT  = 2'd1,
      PH_BIAS = 2'd2
   } phase_t;

   // --------------------------------------------------
   // Window shape and frame layout
   // --------------------------------------------------

   // Cell index is row * WIN_DIM + column
   localparam int WIN_DIM    = 3;
   localparam int WIN_SIZE   = WIN_DIM * WIN_DIM;

   localparam int IFM_WORDS  = 3;
   localparam int WGT_WORDS  = 3;
   localparam int BIAS_WORDS = 1;

   // Image word commands, unknown values act as a column load
   localparam cmd_t CMD_LOAD  = 8'h00;
   localparam cmd_t CMD_RIGHT = 8'h01;
   localparam cmd_t CMD_LEFT  = 8'h02;
   localparam cmd_t CMD_DOWN  = 8'hFF;

endpackage

// File: src/load_fsm.sv
`timescale 1ns/100ps

module load_fsm (
   input  logic                 clk,
   input  logic                 rst_n,
   input  logic                 conv_en,
   input  logic                 phase_last,
   output main_buf_pkg::phase_t phase,
   output logic                 ready_load
);

   main_buf_pkg::phase_t phase_nxt;
   logic                 bias_taken;

   // Last word of the frame accepted at this edge
   assign bias_taken = conv_en && phase_last && (phase == main_buf_pkg::PH_BIAS);

   // --------------------------------------------------
   // Next phase
   // --------------------------------------------------
   always_comb
   begin
      phase_nxt = phase;
      if (conv_en && phase_last)
      begin
         case (phase)
            main_buf_pkg::PH_IFM:
               phase_nxt = main_buf_pkg::PH_WGT;
            main_buf_pkg::PH_WGT:
               phase_nxt = main_buf_pkg::PH_BIAS;
            default:
               phase_nxt = main_buf_pkg::PH_IFM;
         endcase
      end
   end

   // --------------------------------------------------
   // State and ready pulse
   // --------------------------------------------------
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         phase      <= main_buf_pkg::PH_IFM;
         ready_load <= 1'b0;
      end
      else
      begin
         phase      <= phase_nxt;
         // One cycle wide, lines up with the new bias value
         ready_load <= bias_taken;
      end
   end

endmodule

// File: src/word_counter.sv
`timescale 1ns/100ps

module word_counter (
   input  logic                 clk,
   input  logic                 rst_n,
   input  logic                 conv_en,
   input  main_buf_pkg::phase_t phase,
   output main_buf_pkg::idx_t   word_idx,
   output logic                 phase_last
);

   main_buf_pkg::idx_t last_idx;

   // Index of the final word in each phase
   always_comb
   begin
      case (phase)
         main_buf_pkg::PH_IFM:
            last_idx = main_buf_pkg::idx_t'(main_buf_pkg::IFM_WORDS - 1);
         main_buf_pkg::PH_WGT:
            last_idx = main_buf_pkg::idx_t'(main_buf_pkg::WGT_WORDS - 1);
         default:
            last_idx = main_buf_pkg::idx_t'(main_buf_pkg::BIAS_WORDS - 1);
      endcase
   end

   assign phase_last = (word_idx == last_idx);

   // Stalls while conv_en is low, wraps on the last word
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         word_idx <= '0;
      else if (conv_en)
      begin
         if (phase_last)
            word_idx <= '0;
         else
            word_idx <= word_idx + 2'd1;
      end
   end

endmodule

// File: src/ifm_window.sv
`timescale 1ns/100ps

module ifm_window (
   input  logic                 clk,
   input  logic                 rst_n,
   input  logic                 wr_en,
   input  main_buf_pkg::idx_t   word_idx,
   input  main_buf_pkg::word_t  data_in,
   output main_buf_pkg::pixel_t ifm_win [main_buf_pkg::WIN_SIZE]
);

   localparam int DIM = main_buf_pkg::WIN_DIM;

   main_buf_pkg::cmd_t   cmd;
   main_buf_pkg::pixel_t col_in [DIM];
   logic                 col_load;
   logic                 shift_r;
   logic                 shift_l;

   assign cmd = main_buf_pkg::cmd_t'(data_in[31:24]);

   // Byte r of the word feeds row r, top byte first
   always_comb
   begin
      for (int r = 0; r < DIM; r++)
         col_in[r] = data_in[23 - 8*r -: 8];
   end

   // --------------------------------------------------
   // Command decode
   // --------------------------------------------------
   always_comb
   begin
      col_load = 1'b0;
      shift_r  = 1'b0;
      shift_l  = 1'b0;
      case (cmd)
         main_buf_pkg::CMD_LOAD:  col_load = 1'b1;
         main_buf_pkg::CMD_RIGHT: shift_r  = 1'b1;
         main_buf_pkg::CMD_LEFT:  shift_l  = 1'b1;
         main_buf_pkg::CMD_DOWN:  ;
         // Unknown commands load a column
         default:                 col_load = 1'b1;
      endcase
   end

   // --------------------------------------------------
   // Window registers
   // --------------------------------------------------
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         for (int i = 0; i < main_buf_pkg::WIN_SIZE; i++)
            ifm_win[i] <= '0;
      end
      else if (wr_en)
      begin
         if (col_load)
         begin
            if (word_idx < DIM)
            begin
               for (int r = 0; r < DIM; r++)
                  ifm_win[r*DIM + int'(word_idx)] <= col_in[r];
            end
         end
         else if (shift_r)
         begin
            // Window moves right, new column enters at 2
            for (int r = 0; r < DIM; r++)
            begin
               for (int c = 0; c < DIM - 1; c++)
                  ifm_win[r*DIM + c] <= ifm_win[r*DIM + c + 1];
               ifm_win[r*DIM + DIM - 1] <= col_in[r];
            end
         end
         else if (shift_l)
         begin
            for (int r = 0; r < DIM; r++)
            begin
               for (int c = 1; c < DIM; c++)
                  ifm_win[r*DIM + c] <= ifm_win[r*DIM + c - 1];
               ifm_win[r*DIM] <= col_in[r];
            end
         end
         else
         begin
            // Down shift, bytes become the bottom row
            for (int c = 0; c < DIM; c++)
            begin
               for (int r = 0; r < DIM - 1; r++)
                  ifm_win[r*DIM + c] <= ifm_win[(r + 1)*DIM + c];
               ifm_win[(DIM - 1)*DIM + c] <= col_in[c];
            end
         end
      end
   end

endmodule

// File: src/kernel_buf.sv
`timescale 1ns/100ps

module kernel_buf (
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic                  wgt_en,
   input  logic                  bias_en,
   input  main_buf_pkg::idx_t    word_idx,
   input  main_buf_pkg::word_t   data_in,
   output main_buf_pkg::weight_t wgt_win [main_buf_pkg::WIN_SIZE],
   output main_buf_pkg::bias_t   bias
);

   localparam int DIM = main_buf_pkg::WIN_DIM;

   main_buf_pkg::weight_t col_in [DIM];

   // Same byte layout as image words, command byte ignored
   always_comb
   begin
      for (int r = 0; r < DIM; r++)
         col_in[r] = main_buf_pkg::weight_t'(data_in[23 - 8*r -: 8]);
   end

   // --------------------------------------------------
   // Weight window, one column per word
   // --------------------------------------------------
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         for (int i = 0; i < main_buf_pkg::WIN_SIZE; i++)
            wgt_win[i] <= '0;
      end
      else if (wgt_en && (word_idx < DIM))
      begin
         for (int r = 0; r < DIM; r++)
            wgt_win[r*DIM + int'(word_idx)] <= col_in[r];
      end
   end

   // --------------------------------------------------
   // Bias register
   // --------------------------------------------------
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         bias <= '0;
      else if (bias_en)
         bias <= main_buf_pkg::bias_t'(data_in);
   end

endmodule

// File: src/main_buf.sv
`timescale 1ns/100ps

module main_buf (
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic                  conv_en,
   input  main_buf_pkg::word_t   data_in,
   output logic                  ready_load,
   output main_buf_pkg::pixel_t  ifm_win [main_buf_pkg::WIN_SIZE],
   output main_buf_pkg::weight_t wgt_win [main_buf_pkg::WIN_SIZE],
   output main_buf_pkg::bias_t   bias
);

   main_buf_pkg::phase_t phase;
   main_buf_pkg::idx_t   word_idx;
   logic                 phase_last;
   logic                 ifm_wr;
   logic                 wgt_wr;
   logic                 bias_wr;

   // Per-phase write strobes
   assign ifm_wr  = conv_en && (phase == main_buf_pkg::PH_IFM);
   assign wgt_wr  = conv_en && (phase == main_buf_pkg::PH_WGT);
   assign bias_wr = conv_en && (phase == main_buf_pkg::PH_BIAS);

   // --------------------------------------------------
   // Frame control
   // --------------------------------------------------
   load_fsm u_load_fsm (
      .clk        (clk),
      .rst_n      (rst_n),
      .conv_en    (conv_en),
      .phase_last (phase_last),
      .phase      (phase),
      .ready_load (ready_load)
   );

   word_counter u_word_counter (
      .clk        (clk),
      .rst_n      (rst_n),
      .conv_en    (conv_en),
      .phase      (phase),
      .word_idx   (word_idx),
      .phase_last (phase_last)
   );

   // --------------------------------------------------
   // Buffers
   // --------------------------------------------------
   ifm_window u_ifm_window (
      .clk      (clk),
      .rst_n    (rst_n),
      .wr_en    (ifm_wr),
      .word_idx (word_idx),
      .data_in  (data_in),
      .ifm_win  (ifm_win)
   );

   kernel_buf u_kernel_buf (
      .clk      (clk),
      .rst_n    (rst_n),
      .wgt_en   (wgt_wr),
      .bias_en  (bias_wr),
      .word_idx (word_idx),
      .data_in  (data_in),
      .wgt_win  (wgt_win),
      .bias     (bias)
   );

endmodule

// File: tests/main_buf_sva.sv
`timescale 1ns/100ps

module main_buf_sva (
   input logic                  clk,
   input logic                  rst_n,
   input logic                  conv_en,
   input logic                  ready_load,
   input main_buf_pkg::pixel_t  ifm_win [main_buf_pkg::WIN_SIZE],
   input main_buf_pkg::weight_t wgt_win [main_buf_pkg::WIN_SIZE],
   input main_buf_pkg::bias_t   bias
);

   logic [8*main_buf_pkg::WIN_SIZE-1:0] ifm_flat;
   logic [8*main_buf_pkg::WIN_SIZE-1:0] wgt_flat;

   // Windows packed into vectors for $stable
   always_comb
   begin
      for (int i = 0; i < main_buf_pkg::WIN_SIZE; i++)
      begin
         ifm_flat[8*i +: 8] = ifm_win[i];
         wgt_flat[8*i +: 8] = wgt_win[i];
      end
   end

   a_ready_single: assert property (@(posedge clk) disable iff (!rst_n)
      ready_load |=> !ready_load)
      else $error("ready_load stayed high for two cycles");

   a_ready_after_en: assert property (@(posedge clk) disable iff (!rst_n)
      ready_load |-> $past(conv_en))
      else $error("ready_load high without an accepted word");

   // No write while the stream is paused
   a_hold: assert property (@(posedge clk) disable iff (!rst_n)
      !conv_en |=> ($stable(ifm_flat) && $stable(wgt_flat) && $stable(bias)))
      else $error("outputs changed while conv_en was low");

endmodule

bind main_buf main_buf_sva u_sva (.*);

// File: tests/main_buf_tb.sv
`timescale 1ns/100ps

module main_buf_tb;

   localparam int DIM = main_buf_pkg::WIN_DIM;

   logic                  clk;
   logic                  rst_n;
   logic                  conv_en;
   main_buf_pkg::word_t   data_in;
   logic                  ready_load;
   main_buf_pkg::pixel_t  ifm_win [main_buf_pkg::WIN_SIZE];
   main_buf_pkg::weight_t wgt_win [main_buf_pkg::WIN_SIZE];
   main_buf_pkg::bias_t   bias;

   // Reference model of both windows and the bias
   main_buf_pkg::pixel_t  m_ifm [main_buf_pkg::WIN_SIZE];
   main_buf_pkg::weight_t m_wgt [main_buf_pkg::WIN_SIZE];
   main_buf_pkg::bias_t   m_bias;

   int err_cnt;
   int test_cnt;
   int cycle_cnt;
   int pulse_cnt;

   main_buf UUT (
      .clk        (clk),
      .rst_n      (rst_n),
      .conv_en    (conv_en),
      .data_in    (data_in),
      .ready_load (ready_load),
      .ifm_win    (ifm_win),
      .wgt_win    (wgt_win),
      .bias       (bias)
   );

   initial
   begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   always @(posedge clk)
      cycle_cnt <= cycle_cnt + 1;

   // --------------------------------------------------
   // Compare tasks
   // --------------------------------------------------
   task automatic check_pixel(input int idx, input main_buf_pkg::pixel_t got,
                              input main_buf_pkg::pixel_t exp);
      if (got !== exp)
      begin
         $display("ERR %0t: ifm_win[%0d] is %0h, expected %0h", $time, idx, got, exp);
         err_cnt++;
      end
   endtask

   task automatic check_weight(input int idx, input main_buf_pkg::weight_t got,
                               input main_buf_pkg::weight_t exp);
      if (got !== exp)
      begin
         $display("ERR %0t: wgt_win[%0d] is %0d, expected %0d", $time, idx, got, exp);
         err_cnt++;
      end
   endtask

   task automatic check_bias(input main_buf_pkg::bias_t got, input main_buf_pkg::bias_t exp);
      if (got !== exp)
      begin
         $display("ERR %0t: bias is %0d, expected %0d", $time, got, exp);
         err_cnt++;
      end
   endtask

   task automatic check_flag(input string name, input logic got, input logic exp);
      if (got !== exp)
      begin
         $display("ERR %0t: %s is %b, expected %b", $time, name, got, exp);
         err_cnt++;
      end
   endtask

   task automatic compare_outputs();
      for (int i = 0; i < main_buf_pkg::WIN_SIZE; i++)
      begin
         check_pixel(i, ifm_win[i], m_ifm[i]);
         check_weight(i, wgt_win[i], m_wgt[i]);
      end
      check_bias(bias, m_bias);
   endtask

   // --------------------------------------------------
   // Reference model and stimulus
   // --------------------------------------------------
   task automatic model_ifm_word(input int idx, input main_buf_pkg::word_t w);
      main_buf_pkg::pixel_t b [DIM];
      b[0] = w[23:16];
      b[1] = w[15:8];
      b[2] = w[7:0];
      case (main_buf_pkg::cmd_t'(w[31:24]))
         main_buf_pkg::CMD_RIGHT:
            for (int r = 0; r < DIM; r++)
            begin
               m_ifm[r*DIM]     = m_ifm[r*DIM + 1];
               m_ifm[r*DIM + 1] = m_ifm[r*DIM + 2];
               m_ifm[r*DIM + 2] = b[r];
            end
         main_buf_pkg::CMD_LEFT:
            for (int r = 0; r < DIM; r++)
            begin
               m_ifm[r*DIM + 2] = m_ifm[r*DIM + 1];
               m_ifm[r*DIM + 1] = m_ifm[r*DIM];
               m_ifm[r*DIM]     = b[r];
            end
         main_buf_pkg::CMD_DOWN:
            for (int c = 0; c < DIM; c++)
            begin
               m_ifm[c]         = m_ifm[DIM + c];
               m_ifm[DIM + c]   = m_ifm[2*DIM + c];
               m_ifm[2*DIM + c] = b[c];
            end
         default:
            for (int r = 0; r < DIM; r++)
               m_ifm[r*DIM + idx] = b[r];
      endcase
   endtask

   function automatic main_buf_pkg::cmd_t random_load_cmd();
      main_buf_pkg::cmd_t c;
      do
         c = main_buf_pkg::cmd_t'($urandom_range(0, 255));
      while (c == main_buf_pkg::CMD_RIGHT || c == main_buf_pkg::CMD_LEFT ||
             c == main_buf_pkg::CMD_DOWN);
      return c;
   endfunction

   task automatic send_word(input main_buf_pkg::word_t w);
      data_in = w;
      conv_en = 1'b1;
      @(posedge clk);
      #1;
      if (ready_load === 1'b1)
         pulse_cnt++;
   endtask

   // Optional stall of 5 cycles after weight word stall_at
   // A negative stall_at sends the frame without a pause
   task automatic send_frame(input main_buf_pkg::cmd_t c0, input main_buf_pkg::cmd_t c1,
                             input main_buf_pkg::cmd_t c2, input int stall_at);
      main_buf_pkg::word_t w;
      main_buf_pkg::cmd_t  cmds [DIM];
      cmds[0] = c0;
      cmds[1] = c1;
      cmds[2] = c2;
      for (int i = 0; i < main_buf_pkg::IFM_WORDS; i++)
      begin
         w = {cmds[i], 24'($urandom())};
         model_ifm_word(i, w);
         send_word(w);
      end
      for (int i = 0; i < main_buf_pkg::WGT_WORDS; i++)
      begin
         w = $urandom();
         m_wgt[i]         = main_buf_pkg::weight_t'(w[23:16]);
         m_wgt[DIM + i]   = main_buf_pkg::weight_t'(w[15:8]);
         m_wgt[2*DIM + i] = main_buf_pkg::weight_t'(w[7:0]);
         send_word(w);
         if (i == stall_at)
         begin
            conv_en = 1'b0;
            data_in = $urandom();
            repeat (5)
            begin
               @(posedge clk);
               #1;
               compare_outputs();
               check_flag("ready_load", ready_load, 1'b0);
            end
         end
      end
      w = $urandom();
      m_bias = main_buf_pkg::bias_t'(w);
      send_word(w);
   endtask

   task automatic wait_ready();
      int n;
      n = 0;
      while (ready_load !== 1'b1 && n < 20)
      begin
         @(posedge clk);
         #1;
         n++;
      end
      if (ready_load !== 1'b1)
      begin
         $display("Timeout: ready_load did not pulse within 20 cycles at %0t", $time);
         err_cnt++;
      end
   endtask

   task automatic end_test(input string name, input int errs_before);
      test_cnt++;
      $display("%s finished with %0d errors", name, err_cnt - errs_before);
   endtask

   // --------------------------------------------------
   // Tests
   // --------------------------------------------------
   task automatic reset_values();
      int e;
      e = err_cnt;
      check_flag("ready_load", ready_load, 1'b0);
      compare_outputs();
      end_test("reset", e);
   endtask

   task automatic full_load();
      int e;
      e = err_cnt;
      send_frame(random_load_cmd(), random_load_cmd(), random_load_cmd(), -1);
      wait_ready();
      conv_en = 1'b0;
      compare_outputs();
      end_test("full frame load", e);
   endtask

   task automatic shift_frames();
      int e;
      e = err_cnt;
      send_frame(random_load_cmd(), random_load_cmd(), random_load_cmd(), -1);
      wait_ready();
      send_frame(main_buf_pkg::CMD_RIGHT, main_buf_pkg::CMD_RIGHT, main_buf_pkg::CMD_LEFT, -1);
      wait_ready();
      conv_en = 1'b0;
      compare_outputs();
      send_frame(main_buf_pkg::CMD_DOWN, main_buf_pkg::CMD_DOWN, main_buf_pkg::CMD_DOWN, -1);
      wait_ready();
      conv_en = 1'b0;
      compare_outputs();
      send_frame(main_buf_pkg::CMD_LEFT, main_buf_pkg::CMD_DOWN, main_buf_pkg::CMD_RIGHT, -1);
      wait_ready();
      conv_en = 1'b0;
      compare_outputs();
      end_test("shifts", e);
   endtask

   task automatic weight_stall();
      int e;
      e = err_cnt;
      send_frame(random_load_cmd(), random_load_cmd(), random_load_cmd(), 1);
      wait_ready();
      conv_en = 1'b0;
      compare_outputs();
      end_test("stall", e);
   endtask

   task automatic repeated_frames();
      int e;
      int p0;
      int last;
      e = err_cnt;
      p0 = pulse_cnt;
      last = -1;
      for (int k = 0; k < 20; k++)
      begin
         send_frame(main_buf_pkg::cmd_t'($urandom_range(0, 255)),
                    main_buf_pkg::cmd_t'($urandom_range(0, 255)),
                    main_buf_pkg::cmd_t'($urandom_range(0, 255)), -1);
         wait_ready();
         if (last >= 0 && cycle_cnt - last != 7)
         begin
            $display("ERR %0t: ready_load spacing %0d cycles, expected 7",
                     $time, cycle_cnt - last);
            err_cnt++;
         end
         last = cycle_cnt;
         compare_outputs();
      end
      conv_en = 1'b0;
      if (pulse_cnt - p0 != 20)
      begin
         $display("ERR %0t: %0d ready_load pulses, expected 20", $time, pulse_cnt - p0);
         err_cnt++;
      end
      end_test("repeated frames", e);
   endtask

   initial
   begin
      void'($urandom(88));
      rst_n    = 1'b0;
      conv_en  = 1'b0;
      data_in  = '0;
      err_cnt  = 0;
      test_cnt = 0;
      for (int i = 0; i < main_buf_pkg::WIN_SIZE; i++)
      begin
         m_ifm[i] = '0;
         m_wgt[i] = '0;
      end
      m_bias = '0;
      repeat (3) @(posedge clk);
      #1;
      rst_n = 1'b1;
      reset_values();
      full_load();
      shift_frames();
      weight_stall();
      repeated_frames();
      $display("Tests run: %0d, errors: %0d", test_cnt, err_cnt);
      if (err_cnt == 0)
         $display("All tests passed!");
      else
         $display("Test failures found");
      $finish;
   end

endmodule

// File: all.f
src/main_buf_pkg.sv
src/load_fsm.sv
src/word_counter.sv
src/ifm_window.sv
src/kernel_buf.sv
src/main_buf.sv
tests/main_buf_sva.sv
tests/main_buf_tb.sv
